// ==== src/fb_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// shared types and constants for the frame-buffer video core
// pixel and memory word layout, stream and raster structs, mode enums
// and the fixed pipeline constants of the memory port and scan-out
////////////////////////////////////////////////////////////////////////////

package fb_pkg;

   // one pixel is 18 bits, one memory word holds two pixels
   localparam int PIX_BITS  = 18;
   localparam int WORD_BITS = 36;

   // cycles from a read request to its data, as on the zbt
   localparam int RD_LATENCY = 2;
   // scan-out asks for its word this many pixels ahead of the raster
   localparam int LOOKAHEAD = 4;

   // 6 bits per channel
   typedef struct packed {
      logic [5:0] r;
      logic [5:0] g;
      logic [5:0] b;
   } pixel_t;

   // left half is the even pixel
   typedef logic [WORD_BITS-1:0] vram_word_t;
   typedef logic [15:0] vram_addr_t;

   // which source owns the write slot
   typedef enum logic [1:0] {
      src_stream  = 2'd0,
      src_pattern = 2'd1
   } src_mode_e;

   // narrow bars use address shift 1, wide bars shift 2
   typedef enum logic {
      bar_narrow = 1'b0,
      bar_wide   = 1'b1
   } bar_width_e;

   typedef struct packed {
      src_mode_e  mode;
      bar_width_e width;
      logic       test_bars;
   } fb_ctrl_t;

   // one write into the buffer
   typedef struct packed {
      vram_addr_t addr;
      vram_word_t data;
   } pix_wr_t;

   // syncs are active low, blank is high outside the active area
   typedef struct packed {
      logic [10:0] x;
      logic [9:0]  y;
      logic        hsync;
      logic        vsync;
      logic        blank;
   } raster_t;

   typedef struct packed {
      pixel_t pix;
      logic   hsync;
      logic   vsync;
      logic   blank;
   } vga_out_t;

endpackage

// ==== src/xga_timing.sv ====
////////////////////////////////////////////////////////////////////////////
// raster timing generator
// free-running x and y counters with active-low sync pulses placed by the
// porch and sync-width parameters, and a blank flag aligned to the counts
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module xga_timing
   import fb_pkg::*;
#(
   parameter int H_ACTIVE = 16,
   parameter int H_FRONT  = 2,
   parameter int H_SYNC   = 3,
   parameter int H_TOTAL  = 26,
   parameter int V_ACTIVE = 8,
   parameter int V_FRONT  = 1,
   parameter int V_SYNC   = 1,
   parameter int V_TOTAL  = 11
) (
   input  logic    clk,
   input  logic    rst,
   output raster_t raster
);

   // horizontal events, decoded on the last count before the change
   logic h_blank_on, h_sync_on, h_sync_off, h_end;
   // vertical events only fire at the end of a line
   logic v_blank_on, v_sync_on, v_sync_off, v_end;
   logic hblank, vblank;
   logic next_hblank, next_vblank;

   assign h_blank_on = (raster.x == 11'(H_ACTIVE - 1));
   assign h_sync_on  = (raster.x == 11'(H_ACTIVE + H_FRONT - 1));
   assign h_sync_off = (raster.x == 11'(H_ACTIVE + H_FRONT + H_SYNC - 1));
   assign h_end      = (raster.x == 11'(H_TOTAL - 1));

   assign v_blank_on = h_end && (raster.y == 10'(V_ACTIVE - 1));
   assign v_sync_on  = h_end && (raster.y == 10'(V_ACTIVE + V_FRONT - 1));
   assign v_sync_off = h_end && (raster.y == 10'(V_ACTIVE + V_FRONT + V_SYNC - 1));
   assign v_end      = h_end && (raster.y == 10'(V_TOTAL - 1));

   // blanking state for the count that follows
   assign next_hblank = h_end ? 1'b0 : (h_blank_on ? 1'b1 : hblank);
   assign next_vblank = v_end ? 1'b0 : (v_blank_on ? 1'b1 : vblank);

   always_ff @(posedge clk) begin
      if (rst) begin
         raster <= '{x: '0, y: '0, hsync: 1'b1, vsync: 1'b1, blank: 1'b0};
         hblank <= 1'b0;
         vblank <= 1'b0;
      end else begin
         raster.x <= h_end ? '0 : raster.x + 11'd1;
         if (h_end) begin
            raster.y <= v_end ? '0 : raster.y + 10'd1;
         end
         hblank <= next_hblank;
         vblank <= next_vblank;
         // sync pulses, active low
         if (h_sync_on) begin
            raster.hsync <= 1'b0;
         end else if (h_sync_off) begin
            raster.hsync <= 1'b1;
         end
         if (v_sync_on) begin
            raster.vsync <= 1'b0;
         end else if (v_sync_off) begin
            raster.vsync <= 1'b1;
         end
         // registered so that it lines up with the new x and y
         raster.blank <= next_vblank | next_hblank;
      end
   end

endmodule

// ==== src/pixel_fifo.sv ====
////////////////////////////////////////////////////////////////////////////
// small ring-buffer FIFO for incoming pixel words
// the sender holds one credit per free entry, every pop returns one
// credit as a single-cycle pulse on the following cycle
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module pixel_fifo
   import fb_pkg::*;
#(
   parameter int FIFO_DEPTH = 4
) (
   input  logic    clk,
   input  logic    rst,
   input  logic    wr_valid,
   input  pix_wr_t wr_word,
   output pix_wr_t head,
   output logic    head_valid,
   input  logic    pop,
   output logic    credit
);

   localparam int PTR_BITS = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_BITS = $clog2(FIFO_DEPTH + 1);

   pix_wr_t             mem [FIFO_DEPTH];
   logic [PTR_BITS-1:0] wr_ptr;
   logic [PTR_BITS-1:0] rd_ptr;
   logic [CNT_BITS-1:0] count;

   // wrap at the depth, which need not be a power of two
   function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] p);
      return (p == PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign head       = mem[rd_ptr];
   assign head_valid = (count != '0);

   // entry storage
   // space is guaranteed by the credits the sender holds
   always_ff @(posedge clk) begin
      if (wr_valid) begin
         mem[wr_ptr] <= wr_word;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         credit <= 1'b0;
      end else begin
         if (wr_valid) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({wr_valid, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         // one credit back per entry taken by the memory
         credit <= pop;
      end
   end

endmodule

// ==== src/bar_pattern_gen.sv ====
////////////////////////////////////////////////////////////////////////////
// bar-pattern source for the frame buffer
// walks every word of the frame, one step per granted write, and builds
// grey bars whose period is set by the narrow or wide width
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module bar_pattern_gen
   import fb_pkg::*;
#(
   parameter int H_ACTIVE = 16,
   parameter int V_ACTIVE = 8
) (
   input  logic       clk,
   input  logic       rst,
   input  bar_width_e width,
   input  logic       grant,
   output pix_wr_t    pat
);

   localparam int FRAME_WORDS = H_ACTIVE * V_ACTIVE / 2;

   vram_addr_t addr;
   vram_addr_t shifted;
   pixel_t     bar_pix;

   // the width picks which address bits form the bar level
   assign shifted = (width == bar_wide) ? (addr >> 2) : (addr >> 1);
   // same 3-bit level on all channels of both pixels
   assign bar_pix = '{r: {shifted[2:0], 3'b000},
                      g: {shifted[2:0], 3'b000},
                      b: {shifted[2:0], 3'b000}};

   assign pat = '{addr: addr, data: {bar_pix, bar_pix}};

   // frame address walk
   always_ff @(posedge clk) begin
      if (rst) begin
         addr <= '0;
      end else if (grant) begin
         addr <= (addr == vram_addr_t'(FRAME_WORDS - 1)) ? '0 : addr + 1'b1;
      end
   end

endmodule

// ==== src/vram_ctrl.sv ====
////////////////////////////////////////////////////////////////////////////
// frame-buffer memory port
// even raster cycles belong to scan-out reads, odd cycles to one write
// from the stream FIFO or the bar pattern, the array returns read data
// two cycles after the request like the external zbt did
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module vram_ctrl
   import fb_pkg::*;
#(
   parameter int H_ACTIVE = 16,
   parameter int V_ACTIVE = 8
) (
   input  logic       clk,
   input  logic       rst,
   input  src_mode_e  mode,
   input  raster_t    raster,
   input  vram_addr_t rd_addr,
   output vram_word_t rd_data,
   input  pix_wr_t    fifo_head,
   input  logic       fifo_valid,
   output logic       fifo_pop,
   input  pix_wr_t    pat,
   output logic       pat_grant
);

   localparam int FRAME_WORDS = H_ACTIVE * V_ACTIVE / 2;
   localparam int ADDR_BITS   = $clog2(FRAME_WORDS);

   vram_word_t mem [FRAME_WORDS];
   vram_word_t rd_pipe [RD_LATENCY];

   logic    rd_en;
   logic    wr_en;
   pix_wr_t wr_cmd;

   ////////////////////////////////////////////////////////////////////////////
   // slot decision

   assign rd_en = ~raster.x[0];
   // stream words go whenever queued, the pattern only during blanking
   assign fifo_pop  = raster.x[0] && (mode == src_stream) && fifo_valid;
   assign pat_grant = raster.x[0] && (mode == src_pattern) && raster.blank;
   assign wr_en     = fifo_pop | pat_grant;
   assign wr_cmd    = (mode == src_stream) ? fifo_head : pat;

   ////////////////////////////////////////////////////////////////////////////
   // array and read pipeline

   // write lands in its own odd slot, never beside a read
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_cmd.addr[ADDR_BITS-1:0]] <= wr_cmd.data;
      end
   end

   // first stage captures the array, later stages only delay
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_pipe[0] <= mem[rd_addr[ADDR_BITS-1:0]];
      end
      for (int i = 1; i < RD_LATENCY; i++) begin
         rd_pipe[i] <= rd_pipe[i-1];
      end
   end

   assign rd_data = rd_pipe[RD_LATENCY-1];

endmodule

// ==== src/vram_scanout.sv ====
////////////////////////////////////////////////////////////////////////////
// scan-out from the frame buffer
// asks for the word LOOKAHEAD pixels ahead of the raster, holds returned
// words until their pixels come up, picks the half for the current x and
// registers the pixel with the syncs and blank one cycle later
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module vram_scanout
   import fb_pkg::*;
#(
   parameter int H_ACTIVE = 16,
   parameter int H_TOTAL  = 26,
   parameter int V_TOTAL  = 11
) (
   input  logic       clk,
   input  logic       rst,
   input  raster_t    raster,
   input  logic       test_bars,
   output vram_addr_t rd_addr,
   input  vram_word_t rd_data,
   output vga_out_t   vga
);

   logic [11:0] x_ahead;
   logic [10:0] x_f;
   logic [9:0]  y_f;
   logic        wrap;
   // next_word holds the fresh read, cur_word the pair on screen
   vram_word_t  next_word;
   vram_word_t  cur_word;
   pixel_t      mem_pix;
   pixel_t      bar_pix;

   ////////////////////////////////////////////////////////////////////////////
   // look-ahead address

   assign x_ahead = 12'(raster.x) + 12'(LOOKAHEAD);
   assign wrap    = (x_ahead >= 12'(H_TOTAL));
   assign x_f     = wrap ? 11'(x_ahead - 12'(H_TOTAL)) : 11'(x_ahead);
   // past the last line the look-ahead falls into the next frame
   assign y_f     = !wrap ? raster.y :
                    (raster.y == 10'(V_TOTAL - 1)) ? '0 : raster.y + 10'd1;

   // two pixels per word
   assign rd_addr = vram_addr_t'(y_f * (H_ACTIVE / 2) + x_f[10:1]);

   ////////////////////////////////////////////////////////////////////////////
   // word latching

   always_ff @(posedge clk) begin
      // data of an even-cycle request shows up RD_LATENCY cycles later
      if (raster.x[0] == 1'(RD_LATENCY % 2)) begin
         next_word <= rd_data;
      end
      // swap in just before the even pixel of the pair
      if (raster.x[0]) begin
         cur_word <= next_word;
      end
   end

   // even pixel in the left half
   assign mem_pix = raster.x[0] ? cur_word[PIX_BITS-1:0] : cur_word[WORD_BITS-1:PIX_BITS];

   // hardwired vertical bars from x, no memory involved
   assign bar_pix = '{r: {raster.x[3:1], 3'b000},
                      g: {raster.x[3:1], 3'b000},
                      b: {raster.x[3:1], 3'b000}};

   ////////////////////////////////////////////////////////////////////////////
   // output register

   always_ff @(posedge clk) begin
      vga.pix <= test_bars ? bar_pix : mem_pix;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         vga.hsync <= 1'b1;
         vga.vsync <= 1'b1;
         vga.blank <= 1'b1;
      end else begin
         vga.hsync <= raster.hsync;
         vga.vsync <= raster.vsync;
         vga.blank <= raster.blank;
      end
   end

endmodule

// ==== src/video_fb_top.sv ====
////////////////////////////////////////////////////////////////////////////
// frame-buffer video core
// raster timing, stream FIFO with credit return, bar-pattern source,
// shared memory port and scan-out, output one cycle after the raster
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module video_fb_top
   import fb_pkg::*;
#(
   parameter int H_ACTIVE   = 16,
   parameter int H_FRONT    = 2,
   parameter int H_SYNC     = 3,
   parameter int H_TOTAL    = 26,
   parameter int V_ACTIVE   = 8,
   parameter int V_FRONT    = 1,
   parameter int V_SYNC     = 1,
   parameter int V_TOTAL    = 11,
   parameter int FIFO_DEPTH = 4
) (
   input  logic     clk,
   input  logic     rst,
   input  fb_ctrl_t ctrl,
   input  logic     wr_valid,
   input  pix_wr_t  wr_word,
   output logic     wr_credit,
   output vga_out_t vga
);

   raster_t    raster;
   pix_wr_t    fifo_head;
   logic       fifo_valid;
   logic       fifo_pop;
   pix_wr_t    pat;
   logic       pat_grant;
   vram_addr_t rd_addr;
   vram_word_t rd_data;

   xga_timing #(
      .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_TOTAL(H_TOTAL),
      .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_TOTAL(V_TOTAL)
   ) u_timing (
      .clk(clk), .rst(rst), .raster(raster)
   );

   // incoming stream, credits go straight back to the sender
   pixel_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
      .clk(clk), .rst(rst), .wr_valid(wr_valid), .wr_word(wr_word),
      .head(fifo_head), .head_valid(fifo_valid), .pop(fifo_pop), .credit(wr_credit)
   );

   bar_pattern_gen #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) u_pattern (
      .clk(clk), .rst(rst), .width(ctrl.width), .grant(pat_grant), .pat(pat)
   );

   vram_ctrl #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) u_vram (
      .clk(clk), .rst(rst), .mode(ctrl.mode), .raster(raster),
      .rd_addr(rd_addr), .rd_data(rd_data),
      .fifo_head(fifo_head), .fifo_valid(fifo_valid), .fifo_pop(fifo_pop),
      .pat(pat), .pat_grant(pat_grant)
   );

   vram_scanout #(.H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL)) u_scanout (
      .clk(clk), .rst(rst), .raster(raster), .test_bars(ctrl.test_bars),
      .rd_addr(rd_addr), .rd_data(rd_data), .vga(vga)
   );

endmodule

// ==== tests/video_fb_checker.sv ====
////////////////////////////////////////////////////////////////////////////
// protocol assertions on the frame-buffer memory port
// bound into every vram_ctrl instance, watches the slot decision
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module video_fb_checker
   import fb_pkg::*;
#(
   parameter int FRAME_WORDS = 64
) (
   input logic       clk,
   input logic       rst,
   input logic       rd_en,
   input logic       wr_en,
   input vram_addr_t wr_addr,
   input logic       fifo_pop,
   input logic       fifo_valid
);

   // one memory access per cycle
   a_no_collision: assert property (@(posedge clk) disable iff (rst)
      !(rd_en && wr_en))
      else $error("read and write granted in the same cycle");

   // writes stay inside the frame
   a_wr_addr: assert property (@(posedge clk) disable iff (rst)
      wr_en |-> (wr_addr < vram_addr_t'(FRAME_WORDS)))
      else $error("write address %0d outside the frame", wr_addr);

   // never pop an empty FIFO
   a_pop_valid: assert property (@(posedge clk) disable iff (rst)
      fifo_pop |-> fifo_valid)
      else $error("FIFO popped while empty");

endmodule

bind vram_ctrl video_fb_checker #(.FRAME_WORDS(FRAME_WORDS)) u_checker (
   .clk(clk), .rst(rst), .rd_en(rd_en), .wr_en(wr_en), .wr_addr(wr_cmd.addr),
   .fifo_pop(fifo_pop), .fifo_valid(fifo_valid)
);

// ==== tests/fb_monitor.sv ====
////////////////////////////////////////////////////////////////////////////
// output monitor for the frame-buffer core
// rebuilds x and y from blank and vsync, checks line, frame and sync
// widths, and compares active pixels against the model frame on request
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module fb_monitor
   import fb_pkg::*;
#(
   parameter int H_ACTIVE = 16,
   parameter int V_ACTIVE = 8,
   parameter int H_SYNC   = 3,
   parameter int V_SYNC   = 1,
   parameter int H_TOTAL  = 26
) (
   input  logic       clk,
   input  logic       rst,
   input  vga_out_t   vga,
   input  logic       check_en,
   input  logic       check_bars,
   input  vram_word_t model [H_ACTIVE*V_ACTIVE/2],
   output int         errors,
   output int         pixels,
   output int         frames
);

   int     x_cnt;
   int     line_cnt;
   int     hs_run;
   int     vs_run;
   logic   prev_blank;
   logic   prev_hs;
   logic   prev_vs;
   pixel_t exp_pix;

   // expected pixel at (x, y), from the bar rule or the model word
   function automatic pixel_t expected_pixel(input int x, input int y);
      vram_word_t w;
      logic [2:0] lvl;
      lvl = 3'((x >> 1) & 7);
      w = model[y * (H_ACTIVE / 2) + x / 2];
      if (check_bars) begin
         return '{r: {lvl, 3'b000}, g: {lvl, 3'b000}, b: {lvl, 3'b000}};
      end
      // even pixel sits in the upper half
      return (x % 2 == 0) ? w[WORD_BITS-1:PIX_BITS] : w[PIX_BITS-1:0];
   endfunction

   // sampled on the falling edge, away from the register updates
   always @(negedge clk) begin
      if (rst) begin
         x_cnt      = 0;
         line_cnt   = 0;
         hs_run     = 0;
         vs_run     = 0;
         prev_blank = 1'b1;
         prev_hs    = 1'b1;
         prev_vs    = 1'b1;
         errors     = 0;
         pixels     = 0;
         frames     = 0;
      end else begin
         if (!vga.blank) begin
            if (check_en && line_cnt < V_ACTIVE && x_cnt < H_ACTIVE) begin
               exp_pix = expected_pixel(x_cnt, line_cnt);
               pixels++;
               if (vga.pix !== exp_pix) begin
                  errors++;
                  $display("Fail at %0t: pixel (%0d,%0d) is %h, expected %h",
                           $time, x_cnt, line_cnt, vga.pix, exp_pix);
               end
            end
            x_cnt++;
         end
         // end of an active line
         if (vga.blank && !prev_blank) begin
            if (x_cnt != H_ACTIVE) begin
               errors++;
               $display("Fail at %0t: line has %0d active pixels, expected %0d",
                        $time, x_cnt, H_ACTIVE);
            end
            line_cnt++;
            x_cnt = 0;
         end
         // hsync pulse width
         if (!vga.hsync) begin
            hs_run++;
         end else if (!prev_hs) begin
            if (hs_run != H_SYNC) begin
               errors++;
               $display("Fail at %0t: hsync low for %0d cycles, expected %0d",
                        $time, hs_run, H_SYNC);
            end
            hs_run = 0;
         end
         // vsync pulse width, counted in cycles
         if (!vga.vsync) begin
            vs_run++;
         end else if (!prev_vs) begin
            if (vs_run != V_SYNC * H_TOTAL) begin
               errors++;
               $display("Fail at %0t: vsync low for %0d cycles, expected %0d",
                        $time, vs_run, V_SYNC * H_TOTAL);
            end
            vs_run = 0;
         end
         // frame boundary on vsync falling
         if (!vga.vsync && prev_vs) begin
            if (line_cnt != V_ACTIVE) begin
               errors++;
               $display("Fail at %0t: frame has %0d active lines, expected %0d",
                        $time, line_cnt, V_ACTIVE);
            end
            line_cnt = 0;
            frames++;
         end
         prev_blank = vga.blank;
         prev_hs    = vga.hsync;
         prev_vs    = vga.vsync;
      end
   end

endmodule

// ==== tests/video_fb_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// testbench for the frame-buffer video core
// runs the phases of the stimulus file, sends stream words under credit
// control, keeps the model frame for the monitor and prints a summary
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module video_fb_tb;
   import fb_pkg::*;

   localparam int H_ACTIVE = 16;
   localparam int H_SYNC = 3;
   localparam int H_TOTAL = 26;
   localparam int V_ACTIVE = 8;
   localparam int V_SYNC = 1;
   localparam int V_TOTAL = 11;
   localparam int FIFO_DEPTH = 4;
   localparam int FRAME_WORDS = H_ACTIVE * V_ACTIVE / 2;
   localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
   localparam int STIM_LEN = 64;

   logic       clk = 1'b0;
   logic       rst;
   fb_ctrl_t   ctrl;
   logic       wr_valid;
   pix_wr_t    wr_word;
   logic       wr_credit;
   vga_out_t   vga;
   vram_word_t model [FRAME_WORDS];
   logic       check_en;
   logic       check_bars;
   int         mon_errors;
   int         mon_pixels;
   int         frame_count;
   logic [55:0] stim [STIM_LEN];
   pix_wr_t    pending [$];
   int         sent;
   int         returned;
   int         cycles;
   int         cycle_limit;
   int         tests;
   int         passed;
   int         errors;
   logic [31:0] rng;

   video_fb_top #(
      .H_ACTIVE(H_ACTIVE), .H_FRONT(2), .H_SYNC(H_SYNC), .H_TOTAL(H_TOTAL),
      .V_ACTIVE(V_ACTIVE), .V_FRONT(1), .V_SYNC(V_SYNC), .V_TOTAL(V_TOTAL),
      .FIFO_DEPTH(FIFO_DEPTH)
   ) video_fb_top_i (
      .clk(clk), .rst(rst), .ctrl(ctrl), .wr_valid(wr_valid), .wr_word(wr_word),
      .wr_credit(wr_credit), .vga(vga)
   );

   fb_monitor #(
      .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .H_SYNC(H_SYNC), .V_SYNC(V_SYNC),
      .H_TOTAL(H_TOTAL)
   ) monitor (
      .clk(clk), .rst(rst), .vga(vga), .check_en(check_en), .check_bars(check_bars),
      .model(model), .errors(mon_errors), .pixels(mon_pixels), .frames(frame_count)
   );

   always #5 clk = ~clk;

   // credit pulses and the run limit
   always @(posedge clk) begin
      cycles++;
      if (!rst && wr_credit) begin
         returned++;
      end
      if (cycles > cycle_limit) begin
         $display("timeout: run went past %0d cycles", cycle_limit);
         $display("TEST FAILED");
         $finish;
      end
   end

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] v;
      v = s ^ (s << 13);
      v = v ^ (v >> 17);
      return v ^ (v << 5);
   endfunction

   function automatic int credits_left();
      return FIFO_DEPTH - sent + returned;
   endfunction

   function automatic int total_errors();
      return errors + mon_errors;
   endfunction

   // bar-pattern word for an address
   function automatic vram_word_t bar_word(input int addr, input bar_width_e width);
      logic [2:0] lvl;
      pixel_t     p;
      lvl = 3'((addr >> ((width == bar_wide) ? 2 : 1)) & 7);
      p = '{r: {lvl, 3'b000}, g: {lvl, 3'b000}, b: {lvl, 3'b000}};
      return {p, p};
   endfunction

   function automatic vram_word_t random_word();
      rng = xorshift(rng);
      random_word[35:32] = rng[3:0];
      rng = xorshift(rng);
      random_word[31:0] = rng;
   endfunction

   task automatic wait_frames(input int n);
      int target;
      target = frame_count + n;
      while (frame_count < target) begin
         @(posedge clk);
      end
      #1;
   endtask

   // waits for a credit, then drives one stream word for a cycle
   task automatic send_word(input pix_wr_t w);
      while (credits_left() == 0) begin
         @(posedge clk);
         #1;
      end
      wr_valid = 1'b1;
      wr_word = w;
      sent++;
      if (ctrl.mode == src_stream) begin
         model[w.addr] = w.data;
      end else begin
         pending.push_back(w);
      end
      @(posedge clk);
      #1;
      wr_valid = 1'b0;
   endtask

   // new mode, and the memory contents it leads to
   task automatic apply_ctrl(input fb_ctrl_t c);
      ctrl = c;
      if (c.mode == src_pattern) begin
         for (int a = 0; a < FRAME_WORDS; a++) begin
            model[a] = bar_word(a, c.width);
         end
      end else begin
         while (pending.size() > 0) begin
            model[pending[0].addr] = pending[0].data;
            void'(pending.pop_front());
         end
      end
   endtask

   task automatic finish_test(input string name, input int start);
      int n;
      n = total_errors() - start;
      tests++;
      if (n == 0) begin
         passed++;
         $display("test %0d %s: ok", tests, name);
      end else begin
         $display("test %0d %s: %0d errors", tests, name, n);
      end
   endtask

   // second frame on from here is compared in full
   task automatic check_frame(input logic bars);
      int start;
      int px0;
      start = total_errors();
      wait_frames(2);
      check_bars = bars;
      check_en = 1'b1;
      px0 = mon_pixels;
      wait_frames(1);
      check_en = 1'b0;
      if (mon_pixels - px0 != H_ACTIVE * V_ACTIVE) begin
         errors++;
         $display("only %0d pixels were compared in the frame", mon_pixels - px0);
      end
      finish_test(bars ? "hardwired bars" : "frame from memory", start);
   endtask

   task automatic expect_credits(input int n);
      int start;
      int waited;
      start = total_errors();
      waited = 0;
      while (credits_left() != n && waited < FRAME_CYCLES) begin
         @(posedge clk);
         #1;
         waited++;
      end
      // nothing more may come back
      repeat (2 * H_TOTAL) @(posedge clk);
      #1;
      if (credits_left() != n) begin
         errors++;
         $display("Fail at %0t: %0d credits held, expected %0d", $time, credits_left(), n);
      end
      finish_test("credit count", start);
   endtask

   // fills the FIFO while it cannot drain and watches for credits
   task automatic stall_send(input int n);
      int start;
      int ret0;
      start = total_errors();
      if (credits_left() < n) begin
         errors++;
         $display("not enough credits to start the stall phase");
      end else begin
         for (int k = 0; k < n; k++) begin
            send_word('{addr: vram_addr_t'(k), data: random_word()});
         end
         ret0 = returned;
         wait_frames(2);
         if (returned != ret0 || credits_left() != 0) begin
            errors++;
            $display("Fail at %0t: %0d credits came back while stalled", $time,
                     returned - ret0);
         end
      end
      finish_test("credit back-pressure", start);
   endtask

   initial begin
      logic [3:0]  op;
      logic [15:0] arg;
      logic [35:0] data;
      int          frames_total;
      int          words_total;
      int          start;
      logic        done;

      cycles = 0;
      cycle_limit = 1000000;
      rst = 1'b1;
      ctrl = '0;
      wr_valid = 1'b0;
      wr_word = '0;
      check_en = 1'b0;
      check_bars = 1'b0;
      sent = 0;
      returned = 0;
      tests = 0;
      passed = 0;
      errors = 0;
      rng = 32'd32114;
      for (int i = 0; i < STIM_LEN; i++) begin
         stim[i] = {4'hf, 52'd0};
      end
      $readmemh("tests/video_fb_stimulus.txt", stim);

      // run limit from the frames and words the phases need
      frames_total = 0;
      words_total = 0;
      for (int i = 0; i < STIM_LEN; i++) begin
         case (stim[i][55:52])
            4'h1: frames_total += int'(stim[i][51:36]);
            4'h2: words_total += 1;
            4'h3: words_total += int'(stim[i][51:36]);
            4'h5: frames_total += 3;
            4'h6: frames_total += 2;
            4'h7: begin
               frames_total += 2;
               words_total += int'(stim[i][51:36]);
            end
            default: ;
         endcase
      end
      cycle_limit = (frames_total + 3) * FRAME_CYCLES + words_total * H_TOTAL + 100;

      repeat (2) @(posedge clk);
      #1;
      rst = 1'b0;

      done = 1'b0;
      for (int i = 0; i < STIM_LEN && !done; i++) begin
         op = stim[i][55:52];
         arg = stim[i][51:36];
         data = stim[i][35:0];
         case (op)
            4'h1: begin
               start = total_errors();
               wait_frames(int'(arg));
               finish_test("raster timing", start);
            end
            4'h2: send_word('{addr: arg, data: data});
            4'h3: begin
               for (int k = 0; k < int'(arg); k++) begin
                  send_word('{addr: vram_addr_t'(k), data: random_word()});
               end
            end
            4'h4: apply_ctrl(fb_ctrl_t'(arg[3:0]));
            4'h5: check_frame(arg[0]);
            4'h6: expect_credits(int'(arg));
            4'h7: stall_send(int'(arg));
            default: done = 1'b1;
         endcase
      end

      $display("%0d tests, %0d passed, %0d failed, %0d errors",
               tests, passed, tests - passed, total_errors());
      if (total_errors() == 0 && passed == tests) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// ==== tests/video_fb_stimulus.txt ====
// columns: op _ arg _ data, one phase per line
// op 1 raster frames, 2 stream word at address arg, 3 random fill of arg words,
// 4 ctrl {mode,width,bars}, 5 frame check (arg 1 = bars), 6 expected credits,
// 7 stall send of arg words, f end
1_0002_000000000
6_0004_000000000
3_0040_000000000
2_0005_fc0fc0fc0
2_003f_03f03f03f
6_0004_000000000
5_0000_000000000
4_0004_000000000
7_0004_000000000
5_0000_000000000
4_0006_000000000
5_0000_000000000
4_0002_000000000
6_0004_000000000
5_0000_000000000
4_0003_000000000
5_0001_000000000
4_0002_000000000
5_0000_000000000
f_0000_000000000

// ==== video_fb_top.f ====
src/fb_pkg.sv
src/xga_timing.sv
src/pixel_fifo.sv
src/bar_pattern_gen.sv
src/vram_ctrl.sv
src/vram_scanout.sv
src/video_fb_top.sv
tests/video_fb_checker.sv
tests/fb_monitor.sv
tests/video_fb_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with verilator, run it, and judge the log
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module video_fb_tb \
   -f video_fb_top.f -o video_fb_sim \
   && { ./obj_dir/video_fb_sim > sim.log 2>&1 || true; }
cat sim.log 2>/dev/null
! grep -q "TEST FAILED" sim.log && grep -q "TEST OK" sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
